// ==== hdl/merge_pkg.sv ====
`default_nettype none

package merge_pkg;

  // Width of one data word on every stream
  localparam int word_w = 8;

  // Data word as carried by producers, FIFOs and the merged output
  typedef logic [word_w-1:0] word_t;

  // FIFO address width, SRAM depth follows from it
  localparam int abits = 4;
  localparam int fifo_depth = 1 << abits;

  // Fill count reported on the level outputs
  // Same width as the SRAM address, so it wraps past fifo_depth - 1 words
  typedef logic [abits-1:0] level_t;

  // Source tag on the merged stream, 0 for channel 0 and 1 for channel 1
  typedef logic [0:0] src_t;

  // Arbiter priority state, names the channel that wins the next contention
  typedef enum logic {
    PRIO_CH0 = 1'b0,
    PRIO_CH1 = 1'b1
  } arb_state_t;

  // FIFO output modes
  // 1 is the smallest block-SRAM FIFO, 2 adds first-word fall-through
  localparam int outreg_ch0 = 2;
  localparam int outreg_ch1 = 1;

endpackage

`default_nettype wire

// ==== hdl/skid_loader.sv ====
`default_nettype none

module skid_loader #(
  // Skip the output register, master side follows the slave side directly
  parameter bit bypass = 1'b0,
  // Allow the temp register to be filled from the t side
  parameter bit loader = 1'b0
) (
  input  wire                     clock,
  input  wire                     reset,

  input  wire                     s_valid_i,
  output logic                    s_ready_o,
  input  wire merge_pkg::word_t   s_data_i,

  input  wire                     t_valid_i,
  output logic                    t_ready_o,
  input  wire merge_pkg::word_t   t_data_i,

  output logic                    m_valid_o,
  input  wire                     m_ready_i,
  output merge_pkg::word_t        m_data_o
);

  // Registered slave ready, high while the temp register is free
  logic s_ready_q;

  // Temp register catches the word that arrives after the master stalls
  logic tmp_valid_q;
  logic tmp_valid_d;
  merge_pkg::word_t tmp_data_q;

  logic s_fire_w;
  logic t_fire_w;
  // Master side can take a new word this cycle
  logic m_free_w;

  assign s_ready_o = s_ready_q;
  assign s_fire_w = s_valid_i && s_ready_q;

  // t side only while the slave word goes straight on to the master side
  assign t_ready_o = loader && !tmp_valid_q && s_fire_w && m_free_w;
  assign t_fire_w = t_valid_i && t_ready_o;

  always_comb begin
    tmp_valid_d = tmp_valid_q;
    if (tmp_valid_q) begin
      // Drains towards the master side
      if (m_free_w) begin
        tmp_valid_d = 1'b0;
      end
    end else if (t_fire_w || (s_fire_w && !m_free_w)) begin
      tmp_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tmp_valid_q <= 1'b0;
      s_ready_q   <= 1'b0;
    end else begin
      tmp_valid_q <= tmp_valid_d;
      s_ready_q   <= !tmp_valid_d;
    end
  end

  // Direct load wins, slave word only lands here when the master is stalled
  always_ff @(posedge clock) begin
    if (!tmp_valid_q) begin
      if (t_fire_w) begin
        tmp_data_q <= t_data_i;
      end else if (s_fire_w && !m_free_w) begin
        tmp_data_q <= s_data_i;
      end
    end
  end

  generate
    if (bypass) begin : g_bypass
      // Held temp word first, else the slave word passes straight through
      assign m_free_w  = m_ready_i;
      assign m_valid_o = tmp_valid_q || s_fire_w;
      assign m_data_o  = tmp_valid_q ? tmp_data_q : s_data_i;
    end else begin : g_outreg
      logic m_valid_q;
      merge_pkg::word_t m_data_q;

      assign m_free_w  = !m_valid_q || m_ready_i;
      assign m_valid_o = m_valid_q;
      assign m_data_o  = m_data_q;

      always_ff @(posedge clock) begin
        if (reset) begin
          m_valid_q <= 1'b0;
        end else if (m_free_w) begin
          m_valid_q <= tmp_valid_q || s_fire_w;
        end
      end

      // Temp register is older than any slave word
      always_ff @(posedge clock) begin
        if (m_free_w) begin
          m_data_q <= tmp_valid_q ? tmp_data_q : s_data_i;
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
  // 1 for plain block SRAM, 2 for first-word fall-through
  parameter int outreg = 1
) (
  input  wire                     clock,
  input  wire                     reset,

  output merge_pkg::level_t       level_o,

  input  wire                     valid_i,
  output logic                    ready_o,
  input  wire merge_pkg::word_t   data_i,

  output logic                    valid_o,
  input  wire                     ready_i,
  output merge_pkg::word_t        data_o
);

  // Block SRAM storage, written and read on the clock edge
  merge_pkg::word_t sram_q [merge_pkg::fifo_depth];

  // Addresses carry one extra bit to tell full from empty
  logic [merge_pkg::abits:0] waddr_q;
  logic [merge_pkg::abits:0] raddr_q;
  logic [merge_pkg::abits:0] waddr_d;
  logic [merge_pkg::abits:0] raddr_d;

  // Registered write-ready and SRAM-not-empty flags
  logic wready_q;
  logic rvalid_q;
  logic full_d;

  // SRAM output register
  logic xvalid_q;
  merge_pkg::word_t xdata_q;

  // Input routing
  logic accept_w;
  logic direct_w;
  logic load_w;
  logic store_w;
  logic fetch_w;
  logic x_taken_w;

  // Skid stage links
  logic s_valid_w;
  logic s_ready_w;
  merge_pkg::word_t s_data_w;
  logic t_valid_w;
  logic t_ready_w;

  // Fill count
  merge_pkg::level_t level_q;

  assign ready_o = wready_q;
  assign level_o = level_q;

  // Input word is taken whenever the SRAM has room
  assign accept_w = valid_i && wready_q;

  // Fall-through path, only when nothing older sits in the SRAM or its
  // output register, and the skid stage has room
  assign direct_w = (outreg == 2) && !rvalid_q && !xvalid_q && s_ready_w;

  // SRAM output word moves on when the skid stage takes it
  assign x_taken_w = xvalid_q && s_ready_w;

  // Skid slave side carries the SRAM word, or the input word on fall-through
  assign s_valid_w = xvalid_q || (direct_w && accept_w);
  assign s_data_w = xvalid_q ? xdata_q : data_i;

  // Input may also go straight into the skid temp register while the SRAM
  // word moves to the skid output, which keeps the order intact
  assign t_valid_w = (outreg == 2) && !rvalid_q && xvalid_q && accept_w;
  assign load_w = t_valid_w && t_ready_w;

  // Everything else goes through the SRAM
  assign store_w = accept_w && !direct_w && !load_w;

  // Refill the output register when it is empty or being emptied
  assign fetch_w = rvalid_q && (!xvalid_q || x_taken_w);

  // Next addresses
  assign waddr_d = store_w ? waddr_q + 1'b1 : waddr_q;
  assign raddr_d = fetch_w ? raddr_q + 1'b1 : raddr_q;

  // Full one edge ahead, so ready_o can be a register
  assign full_d = (waddr_d[merge_pkg::abits] != raddr_d[merge_pkg::abits]) &&
                  (waddr_d[merge_pkg::abits-1:0] == raddr_d[merge_pkg::abits-1:0]);

  always_ff @(posedge clock) begin
    if (reset) begin
      waddr_q  <= '0;
      raddr_q  <= '0;
      wready_q <= 1'b0;
      rvalid_q <= 1'b0;
      xvalid_q <= 1'b0;
    end else begin
      waddr_q  <= waddr_d;
      raddr_q  <= raddr_d;
      wready_q <= !full_d;
      // Not empty after this edge
      rvalid_q <= waddr_d != raddr_d;
      if (fetch_w) begin
        xvalid_q <= 1'b1;
      end else if (x_taken_w) begin
        xvalid_q <= 1'b0;
      end
    end
  end

  // SRAM write port and registered read port
  always_ff @(posedge clock) begin
    if (store_w) begin
      sram_q[waddr_q[merge_pkg::abits-1:0]] <= data_i;
    end
    if (fetch_w) begin
      xdata_q <= sram_q[raddr_q[merge_pkg::abits-1:0]];
    end
  end

  // Accepted minus delivered words
  always_ff @(posedge clock) begin
    if (reset) begin
      level_q <= '0;
    end else begin
      case ({accept_w, valid_o && ready_i})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Skid stage
  // Mode 1 skips its output register, mode 2 keeps it and allows direct loads
  skid_loader #(
    .bypass(outreg < 2),
    .loader(outreg > 1)
  ) u_skid (
    .clock    (clock),
    .reset    (reset),

    .s_valid_i(s_valid_w),
    .s_ready_o(s_ready_w),
    .s_data_i (s_data_w),

    .t_valid_i(t_valid_w),
    .t_ready_o(t_ready_w),
    .t_data_i (data_i),

    .m_valid_o(valid_o),
    .m_ready_i(ready_i),
    .m_data_o (data_o)
  );

endmodule

`default_nettype wire

// ==== hdl/rr_merge.sv ====
`default_nettype none

module rr_merge (
  input  wire                     clock,
  input  wire                     reset,

  // Channel 0 side
  input  wire                     a_valid_i,
  output logic                    a_ready_o,
  input  wire merge_pkg::word_t   a_data_i,

  // Channel 1 side
  input  wire                     b_valid_i,
  output logic                    b_ready_o,
  input  wire merge_pkg::word_t   b_data_i,

  // Merged, tagged output
  output logic                    valid_o,
  input  wire                     ready_i,
  output merge_pkg::word_t        data_o,
  output merge_pkg::src_t         src_o
);

  // Output register
  logic out_valid_q;
  merge_pkg::word_t out_data_q;
  merge_pkg::src_t out_src_q;

  // Channel preferred on the next contention
  merge_pkg::arb_state_t prio_q;

  logic load_w;
  logic pick_b_w;
  logic grant_a_w;
  logic grant_b_w;

  assign valid_o = out_valid_q;
  assign data_o  = out_data_q;
  assign src_o   = out_src_q;

  // Output register is empty or handed over at this edge
  assign load_w = !out_valid_q || ready_i;

  // b wins when alone, or when both are valid and b holds priority
  assign pick_b_w = b_valid_i && (!a_valid_i || prio_q == merge_pkg::PRIO_CH1);

  // One grant per cycle at most
  assign grant_a_w = load_w && a_valid_i && !pick_b_w;
  assign grant_b_w = load_w && pick_b_w;

  assign a_ready_o = grant_a_w;
  assign b_ready_o = grant_b_w;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_q <= 1'b0;
      prio_q      <= merge_pkg::PRIO_CH0;
    end else begin
      if (load_w) begin
        out_valid_q <= grant_a_w || grant_b_w;
      end
      // Priority passes to the channel that lost
      if (grant_a_w) begin
        prio_q <= merge_pkg::PRIO_CH1;
      end else if (grant_b_w) begin
        prio_q <= merge_pkg::PRIO_CH0;
      end
    end
  end

  // Word and tag of the granted channel
  always_ff @(posedge clock) begin
    if (grant_a_w) begin
      out_data_q <= a_data_i;
      out_src_q  <= merge_pkg::src_t'(1'b0);
    end else if (grant_b_w) begin
      out_data_q <= b_data_i;
      out_src_q  <= merge_pkg::src_t'(1'b1);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stream_merge.sv ====
`default_nettype none

module stream_merge (
  input  wire                     clock,
  input  wire                     reset,

  // Channel 0 producer
  input  wire                     ch0_valid_i,
  output logic                    ch0_ready_o,
  input  wire merge_pkg::word_t   ch0_data_i,
  output merge_pkg::level_t       ch0_level_o,

  // Channel 1 producer
  input  wire                     ch1_valid_i,
  output logic                    ch1_ready_o,
  input  wire merge_pkg::word_t   ch1_data_i,
  output merge_pkg::level_t       ch1_level_o,

  // Merged consumer side
  output logic                    valid_o,
  input  wire                     ready_i,
  output merge_pkg::word_t        data_o,
  output merge_pkg::src_t         src_o
);

  // FIFO to arbiter links
  logic a_valid;
  logic a_ready;
  merge_pkg::word_t a_data;
  logic b_valid;
  logic b_ready;
  merge_pkg::word_t b_data;

  // Channel 0, fall-through mode
  sync_fifo #(
    .outreg(merge_pkg::outreg_ch0)
  ) u_fifo_ch0 (
    .clock  (clock),
    .reset  (reset),
    .level_o(ch0_level_o),
    .valid_i(ch0_valid_i),
    .ready_o(ch0_ready_o),
    .data_i (ch0_data_i),
    .valid_o(a_valid),
    .ready_i(a_ready),
    .data_o (a_data)
  );

  // Channel 1, plain block-SRAM mode
  sync_fifo #(
    .outreg(merge_pkg::outreg_ch1)
  ) u_fifo_ch1 (
    .clock  (clock),
    .reset  (reset),
    .level_o(ch1_level_o),
    .valid_i(ch1_valid_i),
    .ready_o(ch1_ready_o),
    .data_i (ch1_data_i),
    .valid_o(b_valid),
    .ready_i(b_ready),
    .data_o (b_data)
  );

  rr_merge u_merge (
    .clock    (clock),
    .reset    (reset),
    .a_valid_i(a_valid),
    .a_ready_o(a_ready),
    .a_data_i (a_data),
    .b_valid_i(b_valid),
    .b_ready_o(b_ready),
    .b_data_i (b_data),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .data_o   (data_o),
    .src_o    (src_o)
  );

endmodule

`default_nettype wire

// ==== test/stream_merge_assert.sv ====
`default_nettype none

module stream_merge_assert (
  input wire                   clock,
  input wire                   reset,
  input wire                   a_ready_i,
  input wire                   b_ready_i,
  input wire                   valid_i,
  input wire                   ready_i,
  input wire merge_pkg::word_t data_i,
  input wire merge_pkg::src_t  src_i
);

  // Failure counts, read back by the testbench at the end
  int excl_fails = 0;
  int valid_fails = 0;
  int data_fails = 0;
  int src_fails = 0;

  // Only one FIFO drained per cycle
  one_grant: assert property (@(posedge clock) disable iff (reset)
    !(a_ready_i && b_ready_i))
    else begin
      $error("both FIFO readies high in the same cycle");
      excl_fails++;
    end

  // Stalled output keeps its valid, word and tag
  valid_hold: assert property (@(posedge clock) disable iff (reset)
    valid_i && !ready_i |=> valid_i)
    else begin
      $error("merged valid dropped before a transfer");
      valid_fails++;
    end

  data_hold: assert property (@(posedge clock) disable iff (reset)
    valid_i && !ready_i |=> $stable(data_i))
    else begin
      $error("merged data changed before a transfer");
      data_fails++;
    end

  src_hold: assert property (@(posedge clock) disable iff (reset)
    valid_i && !ready_i |=> $stable(src_i))
    else begin
      $error("merged source tag changed before a transfer");
      src_fails++;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clock_o,
  output logic reset_o
);

  // 40 unit period
  initial begin
    clock_o = 1'b0;
    forever #20 clock_o = ~clock_o;
  end

  // Reset held over the first 3 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clock_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/stream_merge_tb.sv ====
`default_nettype none

module stream_merge_tb;

  // Consumer ready patterns
  localparam int rdy_always = 0;
  localparam int rdy_never  = 1;
  localparam int rdy_random = 2;

  localparam int n_phases = 6;
  // Longest any single wait may run, in cycles
  localparam int wait_limit = 400;

  typedef struct packed {
    int n0;
    int n1;
    int rdy;
    int lvl0;
    int lvl1;
    bit alt;
    bit ft;
  } phase_t;

  // Columns: ch0 words, ch1 words, consumer ready, expected ch0 and ch1 level
  // (-1 is not checked), alternation check, fall-through check
  phase_t phases [n_phases] = '{
    '{5,  3,  rdy_never,  4,  3,  1'b0, 1'b0},
    '{10, 10, rdy_random, -1, -1, 1'b0, 1'b0},
    '{6,  6,  rdy_never,  -1, -1, 1'b0, 1'b0},
    '{0,  0,  rdy_always, -1, -1, 1'b1, 1'b0},
    '{1,  0,  rdy_always, -1, -1, 1'b0, 1'b1},
    '{9,  12, rdy_random, -1, -1, 1'b0, 1'b0}
  };

  logic clock;
  logic reset;

  logic ch0_valid_i;
  logic ch0_ready_o;
  merge_pkg::word_t ch0_data_i;
  merge_pkg::level_t ch0_level_o;
  logic ch1_valid_i;
  logic ch1_ready_o;
  merge_pkg::word_t ch1_data_i;
  merge_pkg::level_t ch1_level_o;
  logic valid_o;
  logic ready_i;
  merge_pkg::word_t data_o;
  merge_pkg::src_t src_o;

  integer seed = 84;
  int rdy_mode = rdy_never;
  int checks = 0;
  int errors = 0;

  // Words sent and not yet seen at the output, per channel
  merge_pkg::word_t exp_q0[$];
  merge_pkg::word_t exp_q1[$];
  // Words still to be sent in the current phase
  merge_pkg::word_t stim_q0[$];
  merge_pkg::word_t stim_q1[$];

  // Alternation tracking
  bit alt_on = 1'b0;
  bit alt_seen = 1'b0;
  merge_pkg::src_t alt_last;

  tb_clock u_clock (
    .clock_o(clock),
    .reset_o(reset)
  );

  stream_merge i_dut (
    .clock      (clock),
    .reset      (reset),
    .ch0_valid_i(ch0_valid_i),
    .ch0_ready_o(ch0_ready_o),
    .ch0_data_i (ch0_data_i),
    .ch0_level_o(ch0_level_o),
    .ch1_valid_i(ch1_valid_i),
    .ch1_ready_o(ch1_ready_o),
    .ch1_data_i (ch1_data_i),
    .ch1_level_o(ch1_level_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .data_o     (data_o),
    .src_o      (src_o)
  );

  // Protocol checks on the arbiter ports
  bind rr_merge stream_merge_assert u_assert (
    .clock    (clock),
    .reset    (reset),
    .a_ready_i(a_ready_o),
    .b_ready_i(b_ready_o),
    .valid_i  (valid_o),
    .ready_i  (ready_i),
    .data_i   (data_o),
    .src_i    (src_o)
  );

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  function automatic logic fifo_ready(input int ch);
    return (ch == 0) ? ch0_ready_o : ch1_ready_o;
  endfunction

  task automatic drive_input(input int ch, input logic valid, input merge_pkg::word_t data);
    if (ch == 0) begin
      ch0_valid_i <= valid;
      ch0_data_i  <= data;
    end else begin
      ch1_valid_i <= valid;
      ch1_data_i  <= data;
    end
  endtask

  // Producer, one word per cycle while the FIFO is ready
  task automatic send_words(input int ch, input int count);
    merge_pkg::word_t w;
    int i;
    int guard;
    w = '0;
    for (i = 0; i < count; i++) begin
      if (ch == 0) begin
        w = stim_q0.pop_front();
      end else begin
        w = stim_q1.pop_front();
      end
      @(posedge clock);
      drive_input(ch, 1'b1, w);
      guard = 0;
      @(negedge clock);
      while (fifo_ready(ch) !== 1'b1 && guard < wait_limit) begin
        @(negedge clock);
        guard++;
      end
      if (fifo_ready(ch) !== 1'b1) begin
        errors++;
        $display("Timeout at %0t: ch%0d FIFO never became ready", $time, ch);
        break;
      end
      // Taken on the coming edge
      if (ch == 0) begin
        exp_q0.push_back(w);
      end else begin
        exp_q1.push_back(w);
      end
    end
    if (count > 0) begin
      @(posedge clock);
      drive_input(ch, 1'b0, w);
    end
  endtask

  // Consumer ready, new value on every rising edge
  task automatic drive_ready();
    int r;
    forever begin
      @(posedge clock);
      r = $random(seed);
      case (rdy_mode)
        rdy_always: ready_i <= 1'b1;
        rdy_random: ready_i <= r[0];
        default:    ready_i <= 1'b0;
      endcase
    end
  endtask

  // Scoreboard pop for one merged transfer
  task automatic take_word();
    merge_pkg::word_t want;
    bit both;
    both = (exp_q0.size() > 0) && (exp_q1.size() > 0);
    // Grant has to swap sides while both channels still hold words
    if (alt_on && alt_seen && both) begin
      check_value("src_o", (alt_last == 1'b0) ? 1 : 0, int'(src_o));
    end
    if (alt_on) begin
      alt_seen = 1'b1;
      alt_last = src_o;
    end
    if (src_o == 1'b0) begin
      if (exp_q0.size() == 0) begin
        errors++;
        $display("Extra word %0h tagged ch0 at %0t, nothing was sent", data_o, $time);
      end else begin
        want = exp_q0.pop_front();
        check_value("data_o", int'(want), int'(data_o));
      end
    end else begin
      if (exp_q1.size() == 0) begin
        errors++;
        $display("Extra word %0h tagged ch1 at %0t, nothing was sent", data_o, $time);
      end else begin
        want = exp_q1.pop_front();
        check_value("data_o", int'(want), int'(data_o));
      end
    end
  endtask

  // Output monitor, sampled mid-cycle
  task automatic watch_output();
    bit held;
    merge_pkg::word_t held_data;
    merge_pkg::src_t held_src;
    held = 1'b0;
    forever begin
      @(negedge clock);
      // A stalled word must still be there, unchanged
      if (held) begin
        check_value("valid_o", 1, int'(valid_o));
        check_value("data_o", int'(held_data), int'(data_o));
        check_value("src_o", int'(held_src), int'(src_o));
      end
      held = (valid_o === 1'b1) && (ready_i === 1'b0);
      held_data = data_o;
      held_src = src_o;
      if (valid_o === 1'b1 && ready_i === 1'b1) begin
        take_word();
      end
    end
  endtask

  initial begin
    int p;
    int i;
    int guard;
    int assert_fails;
    ch0_valid_i = 1'b0;
    ch0_data_i = '0;
    ch1_valid_i = 1'b0;
    ch1_data_i = '0;
    ready_i = 1'b0;

    // First cycle after reset
    guard = 0;
    while (reset !== 1'b0 && guard < 10) begin
      @(negedge clock);
      guard++;
    end
    if (reset !== 1'b0) begin
      errors++;
      $display("Timeout: reset was never released");
    end
    check_value("ch0_ready_o", 0, int'(ch0_ready_o));
    check_value("ch1_ready_o", 0, int'(ch1_ready_o));
    check_value("valid_o", 0, int'(valid_o));

    fork
      watch_output();
      drive_ready();
    join_none

    for (p = 0; p < n_phases; p++) begin
      stim_q0.delete();
      stim_q1.delete();
      for (i = 0; i < phases[p].n0; i++) begin
        stim_q0.push_back(merge_pkg::word_t'($random(seed)));
      end
      for (i = 0; i < phases[p].n1; i++) begin
        stim_q1.push_back(merge_pkg::word_t'($random(seed)));
      end
      rdy_mode = phases[p].rdy;
      alt_on = phases[p].alt;
      alt_seen = 1'b0;

      fork
        send_words(0, phases[p].n0);
        send_words(1, phases[p].n1);
      join

      // Single word into an idle ch0 FIFO falls through quickly
      if (phases[p].ft) begin
        guard = 0;
        do begin
          @(negedge clock);
          guard++;
        end while (valid_o !== 1'b1 && guard < 4);
        if (valid_o !== 1'b1) begin
          errors++;
          $display("Timeout: fall-through word missing on valid_o after 4 cycles");
        end
      end

      // Inputs idle for 4 cycles before levels are read
      repeat (4) @(negedge clock);
      if (phases[p].lvl0 >= 0) begin
        check_value("ch0_level_o", phases[p].lvl0, int'(ch0_level_o));
      end
      if (phases[p].lvl1 >= 0) begin
        check_value("ch1_level_o", phases[p].lvl1, int'(ch1_level_o));
      end

      // Drain everything sent so far
      if (phases[p].rdy != rdy_never) begin
        guard = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && guard < wait_limit) begin
          @(negedge clock);
          guard++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
          errors++;
          $display("Timeout: phase %0d did not drain", p);
        end
      end
    end

    repeat (4) @(negedge clock);
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      errors++;
      $display("Words never delivered: %0d on ch0, %0d on ch1",
               exp_q0.size(), exp_q1.size());
    end

    assert_fails = i_dut.u_merge.u_assert.excl_fails + i_dut.u_merge.u_assert.valid_fails +
                   i_dut.u_merge.u_assert.data_fails + i_dut.u_merge.u_assert.src_fails;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/merge_pkg.sv
hdl/skid_loader.sv
hdl/sync_fifo.sv
hdl/rr_merge.sv
hdl/stream_merge.sv
test/stream_merge_assert.sv
test/tb_clock.sv
test/stream_merge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= stream_merge_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := ERRORS FOUND

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation failed"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
